// File: sim.f
common/fb_params_pkg.sv
common/fb_types_pkg.sv
framebuffer/fb_write_decoder.sv
framebuffer/fb_mem_lane.sv
framebuffer/fb_scanout_assembler.sv
design/banked_framebuffer.sv
tb/fb_clock_gen.sv
tb/banked_framebuffer_tb.sv

// File: tb/banked_framebuffer_tb.sv
// testbench for the banked framebuffer
// host writes go into a flat shadow copy, every scan read is checked against it

`timescale 1ns/1ps
`default_nettype none

module banked_framebuffer_tb;

    localparam int unsigned flat_words = 1 << fb_params_pkg::wr_addr_bits;
    localparam int unsigned drain_limit = 16;

    logic ClockA;
    logic rst_n;
    fb_types_pkg::fb_wr_req_t wr_req;
    logic rd_en;
    logic [fb_params_pkg::lane_addr_bits-1:0] rd_addr;
    fb_types_pkg::fb_scan_word_t scan;
    logic rd_valid;

    // every host byte by flat address
    logic [fb_params_pkg::data_bits-1:0] shadow [flat_words];
    // edge at which each lane address last took a write
    int last_wr_edge [fb_params_pkg::lane_depth];

    // reads in flight with the oldest first
    logic [fb_params_pkg::lane_addr_bits-1:0] rd_q [$];
    fb_types_pkg::fb_scan_word_t exp_q [$];
    int issue_q [$];

    // checker scratch
    logic [fb_params_pkg::lane_addr_bits-1:0] got_addr;
    fb_types_pkg::fb_scan_word_t exp_word;
    int issued;

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int valid_run = 0;
    int max_run = 0;
    int seed;

    fb_clock_gen clock_gen_inst (
        .ClockA (ClockA),
        .rst_n  (rst_n)
    );

    banked_framebuffer banked_framebuffer_inst (
        .ClockA   (ClockA),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .scan     (scan),
        .rd_valid (rd_valid)
    );

    // counts rising edges and is read between edges only
    always @(posedge ClockA) begin
        cycle <= cycle + 1;
    end

    // scan word the panel should see for one lane address
    // upper pixel comes from half 0, lower pixel from half 1
    function automatic fb_types_pkg::fb_scan_word_t expected_scan(
        input logic [fb_params_pkg::lane_addr_bits-1:0] addr
    );
        fb_types_pkg::fb_scan_word_t w;
        fb_types_pkg::fb_addr_u a;
        a.flat = '0;
        a.fields.row = addr[fb_params_pkg::lane_addr_bits-1 -: fb_params_pkg::row_bits];
        a.fields.col = addr[fb_params_pkg::col_bits-1:0];
        for (int c = 0; c < fb_params_pkg::bytes_per_pixel; c++) begin
            a.fields.color = c;
            a.fields.half = 1'b0;
            w.upper[c] = shadow[a.flat];
            a.fields.half = 1'b1;
            w.lower[c] = shadow[a.flat];
        end
        return w;
    endfunction

    // background byte that depends on every address bit
    function automatic logic [7:0] fill_pattern(input logic [8:0] flat);
        return (flat[7:0] * 8'd37) ^ {flat[8], 7'h2b};
    endfunction

    // one clock of stimulus with single-edge write and read strobes
    task automatic drive_cycle(
        input logic                                     do_wr,
        input logic [fb_params_pkg::wr_addr_bits-1:0]   wflat,
        input logic [fb_params_pkg::data_bits-1:0]      wdata,
        input logic                                     do_rd,
        input logic [fb_params_pkg::lane_addr_bits-1:0] raddr
    );
        int edge_no;
        fb_types_pkg::fb_addr_u a;
        edge_no = cycle + 1;
        a.flat = wflat;
        // expected value is taken before this cycle's write because a same-edge
        // write is not seen
        if (do_rd) begin
            rd_q.push_back(raddr);
            exp_q.push_back(expected_scan(raddr));
            // cycle in which rd_en goes high
            issue_q.push_back(cycle);
        end
        if (do_wr) begin
            shadow[wflat] = wdata;
            last_wr_edge[{a.fields.row, a.fields.col}] = edge_no;
        end
        wr_req.wr_en = do_wr;
        wr_req.addr.flat = wflat;
        wr_req.data = wdata;
        rd_en = do_rd;
        rd_addr = raddr;
        @(posedge ClockA);
        #1;
        wr_req.wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic write_byte(input logic [8:0] flat, input logic [7:0] data);
        drive_cycle(1'b1, flat, data, 1'b0, '0);
    endtask

    task automatic read_addr(input logic [5:0] addr);
        drive_cycle(1'b0, '0, '0, 1'b1, addr);
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, '0);
    endtask

    // all eight bytes behind one lane address
    task automatic fill_lane_addr(input logic [5:0] addr);
        fb_types_pkg::fb_addr_u a;
        a.fields.row = addr[5:4];
        a.fields.col = addr[3:0];
        for (int h = 0; h < 2; h++) begin
            for (int c = 0; c < fb_params_pkg::bytes_per_pixel; c++) begin
                a.fields.half = h;
                a.fields.color = c;
                write_byte(a.flat, fill_pattern(a.flat));
            end
        end
    endtask

    // wait until every issued read has come back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (rd_q.size() != 0 && waited < drain_limit) begin
            @(posedge ClockA);
            #1;
            waited++;
        end
        assert (rd_q.size() == 0) else begin
            $display("timed out at %0t waiting for rd_valid, %0d reads never returned",
                     $time, rd_q.size());
            errors++;
            rd_q.delete();
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    // checker samples at the falling edge when scan and rd_valid are settled
    always @(negedge ClockA) begin
        if (rd_valid === 1'b1) begin
            valid_run++;
            if (valid_run > max_run) max_run = valid_run;
            assert (rd_q.size() != 0) else begin
                $display("rd_valid went high at %0t with no read pending", $time);
                errors++;
            end
            if (rd_q.size() != 0) begin
                got_addr = rd_q.pop_front();
                exp_word = exp_q.pop_front();
                issued = issue_q.pop_front();
                checks++;
                assert (scan === exp_word) else begin
                    $display("FAILED t=%0t scan (rd_addr %h) expected %h got %h",
                             $time, got_addr, exp_word, scan);
                    errors++;
                end
                assert (cycle - issued == 2) else begin
                    $display("FAILED t=%0t rd_valid latency expected 2 got %0d",
                             $time, cycle - issued);
                    errors++;
                end
            end
        end else begin
            valid_run = 0;
        end
    end

    // hard stop in case stimulus itself gets stuck
    initial begin
        #100000;
        $display("watchdog expired at %0t, stimulus did not complete", $time);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int tmo;
        logic [5:0] rla;
        logic do_rd;
        fb_types_pkg::fb_addr_u a;
        logic [7:0] lane_exp;

        seed = 73;
        void'($urandom(seed));
        wr_req = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        for (int i = 0; i < fb_params_pkg::lane_depth; i++) begin
            last_wr_edge[i] = -100;
        end

        tmo = 0;
        while (rst_n !== 1'b1 && tmo < 20) begin
            @(posedge ClockA);
            tmo++;
        end
        assert (rst_n === 1'b1) else begin
            $display("reset was never released");
            errors++;
        end
        @(posedge ClockA);
        #1;

        // no valid after reset without a read
        for (int i = 0; i < 5; i++) begin
            assert (rd_valid === 1'b0) else begin
                $display("FAILED t=%0t rd_valid expected 0 got %b", $time, rd_valid);
                errors++;
            end
            idle(1);
        end
        fill_lane_addr(6'h00);
        idle(2);
        read_addr(6'h00);
        wait_drain();

        // single byte into half 1, row 2, col 9, colour 3
        fill_lane_addr(6'h29);
        a.fields.half = 1'b1;
        a.fields.row = 2'd2;
        a.fields.col = 4'd9;
        a.fields.color = 2'd3;
        write_byte(a.flat, 8'hc6);
        idle(2);
        read_addr(6'h29);
        wait_drain();
        assert (scan.lower[3] === 8'hc6) else begin
            $display("FAILED t=%0t scan.lower[3] expected c6 got %h", $time, scan.lower[3]);
            errors++;
        end

        // overwrite lower colour 2 twice while the other channels keep the fill bytes
        fill_lane_addr(6'h17);
        idle(2);
        read_addr(6'h17);
        wait_drain();
        a.fields.half = 1'b1;
        a.fields.row = 2'd1;
        a.fields.col = 4'd7;
        a.fields.color = 2'd2;
        write_byte(a.flat, 8'ha5);
        write_byte(a.flat, 8'h3c);
        idle(2);
        read_addr(6'h17);
        wait_drain();
        for (int c = 0; c < fb_params_pkg::bytes_per_pixel; c++) begin
            a.fields.color = c;
            a.fields.half = 1'b0;
            lane_exp = fill_pattern(a.flat);
            assert (scan.upper[c] === lane_exp) else begin
                $display("FAILED t=%0t scan.upper[%0d] expected %h got %h",
                         $time, c, lane_exp, scan.upper[c]);
                errors++;
            end
            a.fields.half = 1'b1;
            lane_exp = (c == 2) ? 8'h3c : fill_pattern(a.flat);
            assert (scan.lower[c] === lane_exp) else begin
                $display("FAILED t=%0t scan.lower[%0d] expected %h got %h",
                         $time, c, lane_exp, scan.lower[c]);
                errors++;
            end
        end

        // random fill of the whole panel, then a full scan
        for (int i = 0; i < flat_words; i++) begin
            write_byte(i, $urandom);
        end
        idle(2);
        for (int i = 0; i < fb_params_pkg::lane_depth; i++) begin
            read_addr(i);
        end
        wait_drain();

        // back-to-back random reads
        max_run = 0;
        for (int i = 0; i < 32; i++) begin
            read_addr($urandom);
        end
        wait_drain();
        assert (max_run >= 32) else begin
            $display("FAILED t=%0t rd_valid run expected 32 got %0d", $time, max_run);
            errors++;
        end

        // mixed traffic with reads only where the last write has settled
        for (int i = 0; i < 300; i++) begin
            rla = $urandom;
            do_rd = ($urandom % 2) && (cycle + 1 >= last_wr_edge[rla] + 2);
            drive_cycle($urandom % 2, $urandom, $urandom, do_rd, rla);
        end
        wait_drain();
        idle(2);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/fb_clock_gen.sv
// testbench clock and reset source
// 4 ns clock, reset held low for the first three rising edges

`timescale 1ns/1ps
`default_nettype none

module fb_clock_gen (
    output logic ClockA,
    output logic rst_n
);

    initial begin
        ClockA = 1'b0;
        forever #2 ClockA = ~ClockA;
    end

    // release lands 1 ns after the third edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge ClockA);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: design/banked_framebuffer.sv
// banked framebuffer top
// byte writes go to one of eight lanes, a read fetches the same address from all
// lanes at once and returns an upper and lower pixel two cycles later

`timescale 1ns/1ps
`default_nettype none

module banked_framebuffer (
    input  wire                                     ClockA,
    input  wire                                     rst_n,
    // host byte write
    input  wire fb_types_pkg::fb_wr_req_t           wr_req,
    // scan-out read
    input  wire                                     rd_en,
    input  wire [fb_params_pkg::lane_addr_bits-1:0] rd_addr,
    output fb_types_pkg::fb_scan_word_t             scan,
    output logic                                    rd_valid
);

    // registered write request per lane
    wire fb_types_pkg::fb_lane_wr_t lane_wr [fb_params_pkg::lanes];

    // read data of each lane, indexed by {half, color}
    wire [fb_params_pkg::data_bits-1:0] lane_q [fb_params_pkg::lanes];

    // address decode and write register
    fb_write_decoder decoder_inst (
        .ClockA  (ClockA),
        .rst_n   (rst_n),
        .wr_req  (wr_req),
        .lane_wr (lane_wr)
    );

    // one RAM per (half, colour channel)
    // every lane sees the same read address, so one read touches all of them
    genvar i;
    generate
        for (i = 0; i < fb_params_pkg::lanes; i++) begin : g_lane
            fb_mem_lane lane_inst (
                .ClockA  (ClockA),
                .rst_n   (rst_n),
                .wr      (lane_wr[i]),
                .rd_en   (rd_en),
                .rd_addr (rd_addr),
                .q       (lane_q[i])
            );
        end
    endgenerate

    // regroup into pixels and time the valid pulse
    fb_scanout_assembler assembler_inst (
        .ClockA   (ClockA),
        .rst_n    (rst_n),
        .rd_en    (rd_en),
        .lane_q   (lane_q),
        .scan     (scan),
        .rd_valid (rd_valid)
    );

endmodule

`default_nettype wire

// File: framebuffer/fb_scanout_assembler.sv
// scan-out assembler
// regroups the parallel lane bytes into the upper and lower pixel of one scan word

`timescale 1ns/1ps
`default_nettype none

module fb_scanout_assembler (
    input  wire                                ClockA,
    input  wire                                rst_n,
    input  wire                                rd_en,
    input  wire [fb_params_pkg::data_bits-1:0] lane_q [fb_params_pkg::lanes],
    output fb_types_pkg::fb_scan_word_t        scan,
    output logic                               rd_valid
);

    // read enable lined up with the lane output registers
    logic rd_en_d;
    // lane bytes sorted into pixels, before the output register
    fb_types_pkg::fb_scan_word_t scan_next;

    // two-stage valid pipe
    // stage 1 matches the lane read, stage 2 matches the scan register
    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            rd_en_d  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_en_d  <= rd_en;
            rd_valid <= rd_en_d;
        end
    end

    // lanes 0..3 are the upper half, lanes 4..7 the lower half
    // inside each half the lane offset is the colour channel
    always_comb begin
        for (int c = 0; c < fb_params_pkg::bytes_per_pixel; c++) begin
            scan_next.upper[c] = lane_q[c];
            scan_next.lower[c] = lane_q[fb_params_pkg::bytes_per_pixel + c];
        end
    end

    // scan only loads when fresh lane data is present, else it holds
    always_ff @(posedge ClockA) begin
        if (rd_en_d) begin
            scan <= scan_next;
        end
    end

    // end to end read latency is two edges, in both directions
    a_valid_after_rd: assert property (
        @(posedge ClockA) disable iff (!rst_n)
        rd_en |-> ##2 rd_valid
    );

    a_no_stray_valid: assert property (
        @(posedge ClockA) disable iff (!rst_n)
        rd_valid |-> $past(rd_en, 2)
    );

endmodule

`default_nettype wire

// File: framebuffer/fb_mem_lane.sv
// one byte-wide framebuffer lane
// write port fed by the decoder, registered read port shared with all lanes

`timescale 1ns/1ps
`default_nettype none

module fb_mem_lane (
    input  wire                                     ClockA,
    input  wire                                     rst_n,
    input  wire fb_types_pkg::fb_lane_wr_t          wr,
    input  wire                                     rd_en,
    input  wire [fb_params_pkg::lane_addr_bits-1:0] rd_addr,
    output logic [fb_params_pkg::data_bits-1:0]     q
);

    // lane storage, one byte per (row, col)
    logic [fb_params_pkg::data_bits-1:0] mem [fb_params_pkg::lane_depth];

    // write side
    // the request is already registered by the decoder, so the RAM is
    // written one edge after the host presented it
    always_ff @(posedge ClockA) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read side
    // a read on the same edge as a write to that cell sees the old byte
    always_ff @(posedge ClockA) begin
        if (!rst_n) begin
            q <= '0;
        end else if (rd_en) begin
            q <= mem[rd_addr];
        end
    end

    // read after write with at least one edge in between returns the new byte
    a_raw: assert property (
        @(posedge ClockA) disable iff (!rst_n)
        (wr.we ##1 (rd_en && rd_addr == $past(wr.addr) && !wr.we))
            |=> (q == $past(wr.data, 2))
    );

endmodule

`default_nettype wire

// File: framebuffer/fb_write_decoder.sv
// write decoder for the banked framebuffer
// splits the host byte address into lane select and lane address, then registers
// one write request per lane

`timescale 1ns/1ps
`default_nettype none

module fb_write_decoder (
    input  wire                        ClockA,
    input  wire                        rst_n,
    input  wire fb_types_pkg::fb_wr_req_t wr_req,
    output fb_types_pkg::fb_lane_wr_t  lane_wr [fb_params_pkg::lanes]
);

    // lane picked by half and colour channel
    fb_types_pkg::fb_lane_idx_t lane_sel;
    // position inside the lane, row then column
    logic [fb_params_pkg::lane_addr_bits-1:0] lane_addr;
    // registered enables gathered for checking
    logic [fb_params_pkg::lanes-1:0] we_vec;

    // lane index is half * bytes_per_pixel + color, which is just the concatenation
    assign lane_sel = {wr_req.addr.fields.half, wr_req.addr.fields.color};
    assign lane_addr = {wr_req.addr.fields.row, wr_req.addr.fields.col};

    // address and data fan out to every lane and only we is lane specific
    always_ff @(posedge ClockA) begin
        for (int i = 0; i < fb_params_pkg::lanes; i++) begin
            lane_wr[i].addr <= lane_addr;
            lane_wr[i].data <= wr_req.data;
            if (!rst_n) begin
                lane_wr[i].we <= 1'b0;
            end else begin
                lane_wr[i].we <= wr_req.wr_en &&
                    (lane_sel == fb_types_pkg::fb_lane_idx_t'(i));
            end
        end
    end

    always_comb begin
        for (int i = 0; i < fb_params_pkg::lanes; i++) begin
            we_vec[i] = lane_wr[i].we;
        end
    end

    // a host byte never lands in two lanes
    a_we_onehot0: assert property (
        @(posedge ClockA) disable iff (!rst_n)
        $onehot0(we_vec)
    );

endmodule

`default_nettype wire

// File: common/fb_types_pkg.sv
// shared framebuffer types
// host write request, per-lane write, pixel and scan word layouts

`default_nettype none

package fb_types_pkg;

    // field view of the host byte address
    // half sits on top so the upper half fills the low addresses
    typedef struct packed {
        logic [fb_params_pkg::half_bits-1:0]  half;
        logic [fb_params_pkg::row_bits-1:0]   row;
        logic [fb_params_pkg::col_bits-1:0]   col;
        logic [fb_params_pkg::color_bits-1:0] color;
    } fb_addr_fields_t;

    // one address word, read either as the linear host address
    // or split into its panel fields
    typedef union packed {
        logic [fb_params_pkg::wr_addr_bits-1:0] flat;
        fb_addr_fields_t                        fields;
    } fb_addr_u;

    // lane select built as {half, color}
    typedef logic [fb_params_pkg::lane_bits-1:0] fb_lane_idx_t;

    // single byte write from the host
    typedef struct packed {
        logic                                wr_en;
        fb_addr_u                            addr;
        logic [fb_params_pkg::data_bits-1:0] data;
    } fb_wr_req_t;

    // registered write going to one lane RAM
    typedef struct packed {
        logic                                     we;
        logic [fb_params_pkg::lane_addr_bits-1:0] addr;
        logic [fb_params_pkg::data_bits-1:0]      data;
    } fb_lane_wr_t;

    // colour bytes of one pixel
    // index c holds channel c, so channel 0 lands in the low byte
    typedef logic [fb_params_pkg::bytes_per_pixel-1:0][fb_params_pkg::data_bits-1:0]
        fb_pixel_t;

    // one scan read: the pixel in the upper half and its twin below
    typedef struct packed {
        fb_pixel_t upper;
        fb_pixel_t lower;
    } fb_scan_word_t;

endpackage

`default_nettype wire

// File: common/fb_params_pkg.sv
// framebuffer geometry for a two-half LED panel
// derives the byte address fields, lane count and lane depth

`default_nettype none

package fb_params_pkg;

    // panel size in pixels
    localparam int unsigned pixel_width = 16;
    localparam int unsigned pixel_height = 8;
    // each half is scanned together with its twin row in the other half
    localparam int unsigned pixel_halfheight = pixel_height / 2;
    // colour bytes per pixel, channel 0 first
    localparam int unsigned bytes_per_pixel = 4;

    // byte address fields, top to bottom: half, row, col, color
    localparam int unsigned half_bits = $clog2(pixel_height / pixel_halfheight);
    localparam int unsigned row_bits = $clog2(pixel_halfheight);
    localparam int unsigned col_bits = $clog2(pixel_width);
    localparam int unsigned color_bits = $clog2(bytes_per_pixel);

    // one lane per (half, colour) pair
    localparam int unsigned lane_bits = half_bits + color_bits;
    localparam int unsigned lanes = 1 << lane_bits;

    // a lane is addressed by row and column, same as the read address
    localparam int unsigned lane_addr_bits = row_bits + col_bits;
    localparam int unsigned lane_depth = 1 << lane_addr_bits;

    // full host byte address
    localparam int unsigned wr_addr_bits = half_bits + lane_addr_bits + color_bits;

    // every lane is one byte wide
    localparam int unsigned data_bits = 8;

endpackage

`default_nettype wire
